/* verilog.f */
+incdir+include
hdl/spr_bus_pkg.sv
hdl/icache_pkg.sv
hdl/icache_sdp_ram.sv
hdl/icache_lru.sv
hdl/icache_refill_if.sv
hdl/icache_ctrl.sv
hdl/icache_refill_engine.sv
hdl/icache_top.sv
verification/tb_icache_mem.sv
verification/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_icache -f verilog.f -o tb_icache_sim \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_icache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "Finished with errors" sim.log; then
   echo "Simulation reported failures, see sim.log"
   exit 1
fi

echo "Simulation passed"
exit 0

/* verification/tb_icache.sv */
// Instruction cache testbench with clock, reset, stimulus table, checks, watchdog and summary
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

module tb_icache
   import spr_bus_pkg::*;
();

   // Row kinds
   localparam logic [1:0] K_FETCH = 2'd0;
   localparam logic [1:0] K_INV   = 2'd1;
   localparam logic [1:0] K_SPR   = 2'd2;
   localparam int NUM_ROWS  = 19;
   localparam int ACK_LIMIT = 150;

   typedef struct packed {
      logic [1:0]  kind;
      logic [15:0] adr;
      logic        hit;
      logic [2:0]  mem_cnt;
   } row_t;

   // Set 3 sees tags 12, 34 and 56 while set 10 holds only tag 00
   // SPR rows carry the invalidate address in the adr column
   localparam row_t STIM [NUM_ROWS] = '{
      {K_FETCH, 16'h1234, 1'b0, 3'd4},
      {K_FETCH, 16'h1230, 1'b1, 3'd0},
      {K_FETCH, 16'h1238, 1'b1, 3'd0},
      {K_FETCH, 16'h123C, 1'b1, 3'd0},
      {K_FETCH, 16'h3430, 1'b0, 3'd4},
      {K_FETCH, 16'h1230, 1'b1, 3'd0},
      {K_FETCH, 16'h3434, 1'b1, 3'd0},
      {K_FETCH, 16'h5638, 1'b0, 3'd4},
      {K_FETCH, 16'h3438, 1'b1, 3'd0},
      {K_FETCH, 16'h123C, 1'b0, 3'd4},
      {K_FETCH, 16'h3430, 1'b1, 3'd0},
      {K_FETCH, 16'h00A8, 1'b0, 3'd4},
      {K_SPR,   16'h1230, 1'b0, 3'd0},
      {K_FETCH, 16'h1234, 1'b1, 3'd0},
      {K_INV,   16'h1230, 1'b0, 3'd0},
      {K_FETCH, 16'h3434, 1'b0, 3'd4},
      {K_FETCH, 16'h1238, 1'b0, 3'd4},
      {K_FETCH, 16'h00A4, 1'b1, 3'd0},
      {K_FETCH, 16'h3430, 1'b1, 3'd0}
   };

   logic                      clk;
   logic                      rst;
   logic                      cpu_req;
   logic [`ICACHE_ADDR_W-1:0] cpu_adr;
   logic                      cpu_ack;
   insn_word_t                cpu_dat;
   logic                      cpu_hit;
   logic                      spr_stb;
   logic                      spr_we;
   logic [15:0]               spr_addr;
   logic [31:0]               spr_dat;
   logic                      spr_ack;
   logic                      mem_req;
   logic [`ICACHE_ADDR_W-1:0] mem_adr;
   logic                      mem_ack;
   insn_word_t                mem_dat;
   int                        err_cnt = 0;
   int                        chk_cnt = 0;
   int                        mem_req_cnt = 0;
   int                        line_base_cnt = 0;

   always #4 clk = ~clk;

   // Memory strobes are counted on the rising edge and read back on the falling edge
   // Line words are requested in order starting at the line base
   always @(posedge clk) begin
      if (mem_req) begin
         check_value("mem_adr_o", {16'h0000, mem_adr},
                     {16'h0000, cpu_adr[`ICACHE_ADDR_W-1:`ICACHE_BLOCK_LOG2],
                      {`ICACHE_BLOCK_LOG2{1'b0}}} + (mem_req_cnt - line_base_cnt) * 4);
         mem_req_cnt++;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_and_finish();
      $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   // Request is held until ack and the word follows the memory data rule
   task automatic run_fetch(input row_t row);
      int         start_cnt;
      int         waited;
      insn_word_t exp_dat;
      start_cnt = mem_req_cnt;
      line_base_cnt = start_cnt;
      waited = 0;
      exp_dat = 32'hC0DE0000 ^ {16'h0000, row.adr[15:2], 2'b00};
      cpu_req = 1'b1;
      cpu_adr = row.adr;
      @(negedge clk);
      while (!cpu_ack && waited < ACK_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      cpu_req = 1'b0;
      if (!cpu_ack) begin
         err_cnt++;
         $display("No fetch acknowledge for address 0x%04h within %0d cycles",
                  row.adr, ACK_LIMIT);
      end else begin
         check_value("cpu_dat_o", cpu_dat, exp_dat);
         check_value("cpu_hit_o", {31'd0, cpu_hit}, {31'd0, row.hit});
         check_value("mem_req_o count", mem_req_cnt - start_cnt, {29'd0, row.mem_cnt});
      end
   endtask

   // One-cycle SPR write with the ack expected one cycle later
   task automatic run_spr(input row_t row, input logic [15:0] spr_adr);
      int start_cnt;
      start_cnt = mem_req_cnt;
      spr_stb = 1'b1;
      spr_we = 1'b1;
      spr_addr = spr_adr;
      spr_dat = {16'h0000, row.adr};
      @(negedge clk);
      spr_stb = 1'b0;
      spr_we = 1'b0;
      check_value("spr_ack_o", {31'd0, spr_ack}, 32'd1);
      check_value("mem_req_o count", mem_req_cnt - start_cnt, {29'd0, row.mem_cnt});
   endtask

   icache_top i_dut (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req),
      .cpu_adr_i  (cpu_adr),
      .cpu_ack_o  (cpu_ack),
      .cpu_dat_o  (cpu_dat),
      .cpu_hit_o  (cpu_hit),
      .spr_stb_i  (spr_stb),
      .spr_we_i   (spr_we),
      .spr_addr_i (spr_addr),
      .spr_dat_i  (spr_dat),
      .spr_ack_o  (spr_ack),
      .mem_req_o  (mem_req),
      .mem_adr_o  (mem_adr),
      .mem_ack_i  (mem_ack),
      .mem_dat_i  (mem_dat)
   );

   tb_icache_mem i_mem (
      .clk       (clk),
      .rst       (rst),
      .mem_req_i (mem_req),
      .mem_adr_i (mem_adr),
      .mem_ack_o (mem_ack),
      .mem_dat_o (mem_dat)
   );

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      cpu_req = 1'b0;
      cpu_adr = '0;
      spr_stb = 1'b0;
      spr_we = 1'b0;
      spr_addr = '0;
      spr_dat = '0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      // Init sweep runs first and the held fetch request waits it out
      for (int i = 0; i < NUM_ROWS; i++) begin
         case (STIM[i].kind)
            K_FETCH: run_fetch(STIM[i]);
            K_INV:   run_spr(STIM[i], `SPR_ICBIR_ADDR);
            default: run_spr(STIM[i], `SPR_ICBIR_ADDR + 16'h0001);
         endcase
         // Gap so the FSM settles back in IDLE
         repeat (2) @(negedge clk);
      end
      report_and_finish();
   end

   // Watchdog budget is 200 cycles per row plus reset
   initial begin
      repeat (16 + NUM_ROWS * 200) @(posedge clk);
      err_cnt++;
      $display("Timeout: run did not complete within %0d cycles", 16 + NUM_ROWS * 200);
      report_and_finish();
   end

endmodule

`default_nettype wire

/* verification/tb_icache_mem.sv */
// Behavioral backing instruction memory with random answer delay and address-derived data
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

module tb_icache_mem
   import spr_bus_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      mem_req_i,
   input  logic [`ICACHE_ADDR_W-1:0] mem_adr_i,
   output logic                      mem_ack_o,
   output insn_word_t                mem_dat_o
);

   // Random delay source, fixed seed for a repeatable run
   int                        seed = 44046;
   int                        wait_cnt = 0;
   logic                      pending = 1'b0;
   logic [`ICACHE_ADDR_W-1:0] lat_adr = '0;
   logic                      ack_q = 1'b0;
   insn_word_t                dat_q = '0;

   assign mem_ack_o = ack_q;
   assign mem_dat_o = dat_q;

   // Outputs change on the falling edge only
   always @(negedge clk) begin
      if (rst) begin
         pending = 1'b0;
         wait_cnt = 0;
         ack_q = 1'b0;
      end else begin
         ack_q = 1'b0;
         if (pending) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
               // Word data is its address folded into a marker
               ack_q = 1'b1;
               dat_q = 32'hC0DE0000 ^ {16'h0000, lat_adr};
               pending = 1'b0;
            end
         end
         // Engine keeps one strobe outstanding, so no overlap here
         if (mem_req_i) begin
            pending = 1'b1;
            lat_adr = mem_adr_i;
            wait_cnt = 1 + ($unsigned($random(seed)) % 4);
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/icache_top.sv */
// Instruction cache top level joining the controller and the refill engine
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

module icache_top
   import spr_bus_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   // CPU fetch port
   input  logic                      cpu_req_i,
   input  logic [`ICACHE_ADDR_W-1:0] cpu_adr_i,
   output logic                      cpu_ack_o,
   output insn_word_t                cpu_dat_o,
   output logic                      cpu_hit_o,
   // SPR port
   input  logic                      spr_stb_i,
   input  logic                      spr_we_i,
   input  logic [15:0]               spr_addr_i,
   input  logic [31:0]               spr_dat_i,
   output logic                      spr_ack_o,
   // Backing instruction memory
   output logic                      mem_req_o,
   output logic [`ICACHE_ADDR_W-1:0] mem_adr_o,
   input  logic                      mem_ack_i,
   input  insn_word_t                mem_dat_i
);

   icache_refill_if u_refill_if ();

   icache_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_dat_o  (cpu_dat_o),
      .cpu_hit_o  (cpu_hit_o),
      .spr_stb_i  (spr_stb_i),
      .spr_we_i   (spr_we_i),
      .spr_addr_i (spr_addr_i),
      .spr_dat_i  (spr_dat_i),
      .spr_ack_o  (spr_ack_o),
      .refill     (u_refill_if.ctrl)
   );

   icache_refill_engine u_refill_engine (
      .clk       (clk),
      .rst       (rst),
      .mem_req_o (mem_req_o),
      .mem_adr_o (mem_adr_o),
      .mem_ack_i (mem_ack_i),
      .mem_dat_i (mem_dat_i),
      .refill    (u_refill_if.engine)
   );

endmodule

`default_nettype wire

/* hdl/icache_refill_engine.sv */
// Refill engine that fetches one cache line as four sequential memory word strobes
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

module icache_refill_engine
   import spr_bus_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   output logic                      mem_req_o,
   output logic [`ICACHE_ADDR_W-1:0] mem_adr_o,
   input  logic                      mem_ack_i,
   input  insn_word_t                mem_dat_i,
   icache_refill_if.engine           refill
);

   // Engine owns the memory port from request to the last word
   logic                                          busy;
   logic [`ICACHE_ADDR_W-`ICACHE_BLOCK_LOG2-1:0]  line_adr;
   logic [`ICACHE_WORD_LOG2-1:0]                  word_cnt;
   logic [`ICACHE_WORD_LOG2-1:0]                  word_nxt;

   assign word_nxt = word_cnt + 1'b1;

   // Each memory answer is forwarded the same cycle
   assign refill.wr_we  = busy && mem_ack_i;
   assign refill.wr_adr = {line_adr, word_cnt, 2'b00};
   assign refill.wr_dat = mem_dat_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy      <= 1'b0;
         word_cnt  <= '0;
         mem_req_o <= 1'b0;
      end else begin
         mem_req_o <= 1'b0;
         if (refill.refill_req) begin
            // Line start, critical word first is not supported
            busy      <= 1'b1;
            line_adr  <= refill.miss_adr[`ICACHE_ADDR_W-1:`ICACHE_BLOCK_LOG2];
            word_cnt  <= '0;
            mem_req_o <= 1'b1;
            mem_adr_o <= refill.miss_adr;
         end else if (refill.wr_we) begin
            if (refill.refill_done) begin
               busy <= 1'b0;
            end else begin
               // Next word only after the previous one came back
               word_cnt  <= word_nxt;
               mem_req_o <= 1'b1;
               mem_adr_o <= {line_adr, word_nxt, 2'b00};
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/icache_ctrl.sv */
// Cache controller with lookup FSM, tag compare, tag and way RAMs, LRU and set invalidate
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

module icache_ctrl
   import icache_pkg::*;
   import spr_bus_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      cpu_req_i,
   input  logic [`ICACHE_ADDR_W-1:0] cpu_adr_i,
   output logic                      cpu_ack_o,
   output insn_word_t                cpu_dat_o,
   output logic                      cpu_hit_o,
   input  logic                      spr_stb_i,
   input  logic                      spr_we_i,
   input  logic [15:0]               spr_addr_i,
   input  logic [31:0]               spr_dat_i,
   output logic                      spr_ack_o,
   icache_refill_if.ctrl             refill
);

   // Tag RAM word is {history, way entries}
   localparam int TAG_RAM_W = 1 + `ICACHE_WAYS * $bits(icache_tag_t);

   icache_state_t                 state;
   logic [`ICACHE_SET_LOG2-1:0]   init_cnt;
   logic                          init_busy;
   logic [`ICACHE_SET_LOG2-1:0]   inv_set;
   logic [`ICACHE_WORD_LOG2-1:0]  refill_cnt;
   logic                          refilled;
   logic [`ICACHE_WAYS-1:0]       victim_q;
   logic                          tag_we;
   logic [`ICACHE_SET_LOG2-1:0]   tag_waddr;
   logic [TAG_RAM_W-1:0]          tag_dout;
   logic                          tag_hist_rd;
   logic                          tag_hist_wr;
   icache_tag_t [`ICACHE_WAYS-1:0] tag_way_rd;
   icache_tag_t [`ICACHE_WAYS-1:0] tag_way_wr;
   insn_word_t                    way_dout [`ICACHE_WAYS];
   insn_word_t                    hit_dat;
   logic [`ICACHE_WAYS-1:0]       way_hit;
   logic [`ICACHE_WAYS-1:0]       access;
   logic [`ICACHE_WAYS-1:0]       victim;
   logic                          hit;
   logic                          lru_hist;
   spr_op_t                       spr_op;
   logic                          spr_take;
   logic                          inv_take;

   // SPR strobes are lost during a refill and during the init sweep
   assign spr_op   = spr_op_t'(spr_we_i);
   assign spr_take = spr_stb_i && !init_busy && (state == IDLE || state == READ);
   assign inv_take = spr_take && spr_op == SPR_WRITE && spr_addr_i == `SPR_ICBIR_ADDR;

   assign {tag_hist_rd, tag_way_rd} = tag_dout;

   // Tag compare, only meaningful in READ
   always_comb begin
      hit_dat = way_dout[0];
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
         way_hit[w] = tag_way_rd[w].valid &&
                      tag_way_rd[w].tag == cpu_adr_i[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
         if (way_hit[w]) begin
            hit_dat = way_dout[w];
         end
      end
   end
   assign hit = |way_hit;

   // Last refill word ends the engine's run
   assign refill.refill_done = (state == REFILL) && refill.wr_we && (refill_cnt == '1);

   // Tag RAM write source
   always_comb begin
      tag_we      = 1'b0;
      tag_waddr   = cpu_adr_i[`ICACHE_BLOCK_LOG2 +: `ICACHE_SET_LOG2];
      tag_hist_wr = tag_hist_rd;
      tag_way_wr  = tag_way_rd;
      access      = '0;
      if (init_busy) begin
         tag_we      = 1'b1;
         tag_waddr   = init_cnt;
         tag_hist_wr = 1'b0;
         tag_way_wr  = '0;
      end else begin
         case (state)
            READ: begin
               // Hit moves the history away from the used way
               if (hit) begin
                  access      = way_hit;
                  tag_hist_wr = lru_hist;
                  tag_we      = 1'b1;
               end
            end
            REFILL: begin
               if (refill.wr_we) begin
                  access    = victim_q;
                  tag_waddr = refill.wr_adr[`ICACHE_BLOCK_LOG2 +: `ICACHE_SET_LOG2];
                  for (int w = 0; w < `ICACHE_WAYS; w++) begin
                     if (victim_q[w] && refill_cnt == '0) begin
                        // Victim line goes stale as soon as its first word changes
                        tag_way_wr[w].valid = 1'b0;
                     end
                     if (victim_q[w] && refill_cnt == '1) begin
                        tag_way_wr[w].valid = 1'b1;
                        tag_way_wr[w].tag   = refill.wr_adr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
                     end
                  end
                  if (refill_cnt == '1) begin
                     tag_hist_wr = lru_hist;
                  end
                  tag_we = (refill_cnt == '0) || (refill_cnt == '1);
               end
            end
            INVALIDATE: begin
               // Lazy invalidate, whole set and its history
               tag_we      = 1'b1;
               tag_waddr   = inv_set;
               tag_hist_wr = 1'b0;
               tag_way_wr  = '0;
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state             <= IDLE;
         init_cnt          <= '0;
         init_busy         <= 1'b1;
         refill_cnt        <= '0;
         refilled          <= 1'b0;
         victim_q          <= '0;
         cpu_ack_o         <= 1'b0;
         spr_ack_o         <= 1'b0;
         refill.refill_req <= 1'b0;
      end else begin
         cpu_ack_o         <= 1'b0;
         refill.refill_req <= 1'b0;
         spr_ack_o         <= spr_take;
         // Init sweep walks every set once
         if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            init_busy <= (init_cnt != '1);
         end
         if (inv_take) begin
            inv_set <= spr_dat_i[`ICACHE_BLOCK_LOG2 +: `ICACHE_SET_LOG2];
         end
         case (state)
            IDLE: begin
               // Request still high in its ack cycle is not a new one
               if (inv_take) begin
                  state <= INVALIDATE;
               end else if (cpu_req_i && !cpu_ack_o && !init_busy) begin
                  state <= READ;
               end
            end
            READ: begin
               if (inv_take) begin
                  state <= INVALIDATE;
               end else if (hit) begin
                  cpu_ack_o <= 1'b1;
                  cpu_dat_o <= hit_dat;
                  cpu_hit_o <= !refilled;
                  refilled  <= 1'b0;
                  state     <= IDLE;
               end else begin
                  victim_q          <= victim;
                  refill.refill_req <= 1'b1;
                  refill.miss_adr   <= {cpu_adr_i[`ICACHE_ADDR_W-1:`ICACHE_BLOCK_LOG2],
                                        {`ICACHE_BLOCK_LOG2{1'b0}}};
                  refill_cnt        <= '0;
                  state             <= REFILL;
               end
            end
            REFILL: begin
               if (refill.wr_we) begin
                  refill_cnt <= refill_cnt + 1'b1;
                  if (refill_cnt == '1) begin
                     // Lookup repeats and now hits
                     refilled <= 1'b1;
                     state    <= IDLE;
                  end
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   icache_sdp_ram #(
      .ADDR_W(`ICACHE_SET_LOG2),
      .DATA_W(TAG_RAM_W)
   ) u_tag_ram (
      .clk     (clk),
      .we_i    (tag_we),
      .waddr_i (tag_waddr),
      .din_i   ({tag_hist_wr, tag_way_wr}),
      .raddr_i (cpu_adr_i[`ICACHE_BLOCK_LOG2 +: `ICACHE_SET_LOG2]),
      .dout_o  (tag_dout)
   );

   // One word per entry, refill writes go to the saved victim only
   for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
      logic way_we;
      assign way_we = (state == REFILL) && refill.wr_we && victim_q[w];
      icache_sdp_ram #(
         .ADDR_W(`ICACHE_WAY_AW),
         .DATA_W($bits(insn_word_t))
      ) u_way_ram (
         .clk     (clk),
         .we_i    (way_we),
         .waddr_i (refill.wr_adr[`ICACHE_TAG_LSB-1:2]),
         .din_i   (refill.wr_dat),
         .raddr_i (cpu_adr_i[`ICACHE_TAG_LSB-1:2]),
         .dout_o  (way_dout[w])
      );
   end

   icache_lru u_lru (
      .history_i (tag_hist_rd),
      .access_i  (access),
      .history_o (lru_hist),
      .victim_o  (victim)
   );

endmodule

`default_nettype wire

/* hdl/icache_refill_if.sv */
// Refill request and refill word stream between cache controller and refill engine
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

interface icache_refill_if
   import spr_bus_pkg::*;
();

   // Miss request, one-cycle strobe with the line-aligned address
   logic                      refill_req;
   logic [`ICACHE_ADDR_W-1:0] miss_adr;

   // One write strobe per returned word
   logic                      wr_we;
   logic [`ICACHE_ADDR_W-1:0] wr_adr;
   insn_word_t                wr_dat;

   // Controller marks the last word of the line
   logic                      refill_done;

   modport ctrl (
      output refill_req, miss_adr, refill_done,
      input  wr_we, wr_adr, wr_dat
   );

   modport engine (
      input  refill_req, miss_adr, refill_done,
      output wr_we, wr_adr, wr_dat
   );

endinterface

`default_nettype wire

/* hdl/icache_lru.sv */
// Two-way LRU history update and one-hot victim selection
`timescale 1ns/100ps
`default_nettype none
`include "icache_consts.svh"

module icache_lru (
   input  logic                    history_i,
   input  logic [`ICACHE_WAYS-1:0] access_i,
   output logic                    history_o,
   output logic [`ICACHE_WAYS-1:0] victim_o
);

   // History bit holds the index of the least recently used way
   // Reset value 0 makes way 0 the first victim of an empty set

   always_comb begin
      // No access keeps the history
      history_o = history_i;
      if (access_i[0]) begin
         // Way 0 just used, way 1 is now the older one
         history_o = 1'b1;
      end else if (access_i[1]) begin
         history_o = 1'b0;
      end
   end

   // Victim before this access
   assign victim_o = {history_i, ~history_i};

endmodule

`default_nettype wire

/* hdl/icache_sdp_ram.sv */
// Single-clock simple dual-port RAM with registered read and no write bypass
`timescale 1ns/100ps
`default_nettype none

module icache_sdp_ram #(
   parameter int ADDR_W = 4,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic [DATA_W-1:0] din_i,
   input  logic [ADDR_W-1:0] raddr_i,
   output logic [DATA_W-1:0] dout_o
);

   // Storage array
   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Same-address read returns the old word
      dout_o <= mem[raddr_i];
   end

endmodule

`default_nettype wire

/* hdl/icache_pkg.sv */
// Cache controller state enum and tag RAM way entry struct
`default_nettype none
`include "icache_consts.svh"

package icache_pkg;

   // Controller states
   // A lookup goes IDLE then READ, a miss adds REFILL before the lookup repeats
   typedef enum logic [1:0] {
      IDLE,
      READ,
      REFILL,
      INVALIDATE
   } icache_state_t;

   // One way's entry in the tag RAM
   // The set word is {lru history, way1 entry, way0 entry}
   typedef struct packed {
      logic                     valid;
      logic [`ICACHE_TAG_W-1:0] tag;
   } icache_tag_t;

endpackage

`default_nettype wire

/* hdl/spr_bus_pkg.sv */
// SPR access opcode enum and the instruction word type used by memory and refill
`default_nettype none

package spr_bus_pkg;

   // Decoded straight from the SPR write enable
   typedef enum logic {
      SPR_READ  = 1'b0,
      SPR_WRITE = 1'b1
   } spr_op_t;

   // Instruction word on the memory port, the refill stream and the CPU port
   typedef logic [31:0] insn_word_t;

endpackage

`default_nettype wire

/* include/icache_consts.svh */
// Address, line, set and way geometry macros plus the block-invalidate SPR address
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Byte address width shared by the fetch port and the memory port
`define ICACHE_ADDR_W 16

// Line size is 16 bytes or four instruction words
`define ICACHE_BLOCK_LOG2 4

// Sixteen sets
`define ICACHE_SET_LOG2 4

// Whatever is left above the set index
`define ICACHE_TAG_W 8

// The LRU history is a single bit, so this stays at two
`define ICACHE_WAYS 2

// Word index inside a line
`define ICACHE_WORD_LOG2 (`ICACHE_BLOCK_LOG2 - 2)

// Way RAM holds one word per entry and is addressed by set and word
`define ICACHE_WAY_AW (`ICACHE_SET_LOG2 + `ICACHE_WORD_LOG2)

// Lowest address bit of the tag
`define ICACHE_TAG_LSB (`ICACHE_BLOCK_LOG2 + `ICACHE_SET_LOG2)

// Block-invalidate register in group 4 of the SPR space
`define SPR_ICBIR_ADDR 16'h2002

`endif
